//--- design/usrp_pkg.sv
/*
 * Shared constants for the clk64 radio control core
 * Bus and sample widths, register map, tx_mux slot fields,
 * mode and control bits, constant readback words, APB FSM states
 */
`default_nettype none

package usrp_pkg;

   // Widths
   localparam int addr_w   = 7;
   localparam int data_w   = 32;
   localparam int sample_w = 16;
   localparam int dac_w    = 14;
   localparam int rate_w   = 8;

   // Register map
   localparam logic [addr_w-1:0] reg_tx_mux      = 7'd1;
   localparam logic [addr_w-1:0] reg_mode        = 7'd2;
   localparam logic [addr_w-1:0] reg_interp_rate = 7'd3;
   localparam logic [addr_w-1:0] reg_decim_rate  = 7'd4;
   localparam logic [addr_w-1:0] reg_master_ctrl = 7'd5;
   localparam logic [addr_w-1:0] reg_caps        = 7'd6;
   localparam logic [addr_w-1:0] reg_id          = 7'd7;

   // DAC slot codes in tx_mux, slot n starts at bit 4+4n
   localparam int dac_slots    = 4;
   localparam int tx_slot0_lsb = 4;
   localparam int slot_code_w  = 4;
   localparam int mux_en_bit   = 3;
   localparam int mux_chan_bit = 1;
   localparam int mux_q_bit    = 0;

   // Mode and master control bits
   localparam int mode_loopback_bit  = 0;
   localparam int mode_counter_bit   = 1;
   localparam int ctrl_enable_tx_bit = 0;
   localparam int ctrl_enable_rx_bit = 1;

   // Read-only words
   localparam logic [data_w-1:0] caps_word = 32'h0000_0022;
   localparam logic [data_w-1:0] id_word   = 32'hF0F0_931A;

   // APB slave states
   localparam logic [1:0] st_idle   = 2'd0;
   localparam logic [1:0] st_setup  = 2'd1;
   localparam logic [1:0] st_access = 2'd2;

endpackage

`default_nettype wire

//--- design/apb_reg_fsm.sv
/*
 * APB slave for the settings bank
 * Zero wait state answer, read data latch, one write strobe per write
 */
`timescale 1ns/1ns
`default_nettype none

module apb_reg_fsm (
   input  wire                          clk64,
   input  wire                          rx_dsp_reset,
   input  wire                          i_psel,
   input  wire                          i_penable,
   input  wire                          i_pwrite,
   input  wire  [usrp_pkg::addr_w-1:0]  i_paddr,
   input  wire  [usrp_pkg::data_w-1:0]  i_pwdata,
   input  wire  [usrp_pkg::data_w-1:0]  i_rdata,
   output logic [usrp_pkg::data_w-1:0]  o_prdata,
   output logic                         o_pready,
   output logic                         o_wr_strobe,
   output logic [usrp_pkg::addr_w-1:0]  o_wr_addr,
   output logic [usrp_pkg::data_w-1:0]  o_wr_data,
   output logic [usrp_pkg::addr_w-1:0]  o_rd_addr
);

   logic [1:0] state;
   logic       start;

   // Setup phase seen on the bus, access follows next cycle
   assign start     = (state != usrp_pkg::st_access) && i_psel && !i_penable;
   assign o_rd_addr = i_paddr;

   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
      begin
         state       <= usrp_pkg::st_idle;
         o_pready    <= 1'b0;
         o_wr_strobe <= 1'b0;
      end
      else
      begin
         o_pready    <= 1'b0;
         o_wr_strobe <= 1'b0;
         if (start)
         begin
            state       <= usrp_pkg::st_access;
            o_pready    <= 1'b1;
            o_wr_strobe <= i_pwrite;
         end
         else if (state == usrp_pkg::st_access)
            state <= usrp_pkg::st_setup;
         else if (!i_psel)
            state <= usrp_pkg::st_idle;
      end
   end

   // Address and data are stable from setup on, so capture them there
   always_ff @(posedge clk64)
   begin
      if (start)
      begin
         o_prdata  <= i_pwrite ? '0 : i_rdata;
         o_wr_addr <= i_paddr;
         o_wr_data <= i_pwdata;
      end
   end

endmodule

`default_nettype wire

//--- design/settings_regs.sv
/*
 * Settings register bank
 * Five writable words, address decode, read mux with caps and id words
 */
`timescale 1ns/1ns
`default_nettype none

module settings_regs (
   input  wire                          clk64,
   input  wire                          rx_dsp_reset,
   input  wire                          i_wr_strobe,
   input  wire  [usrp_pkg::addr_w-1:0]  i_wr_addr,
   input  wire  [usrp_pkg::data_w-1:0]  i_wr_data,
   input  wire  [usrp_pkg::addr_w-1:0]  i_rd_addr,
   output logic [usrp_pkg::data_w-1:0]  o_rdata,
   output logic [usrp_pkg::data_w-1:0]  o_tx_mux,
   output logic                         o_loopback,
   output logic                         o_counter_mode,
   output logic [usrp_pkg::rate_w-1:0]  o_interp_rate,
   output logic [usrp_pkg::rate_w-1:0]  o_decim_rate,
   output logic                         o_enable_tx,
   output logic                         o_enable_rx
);

   logic [usrp_pkg::data_w-1:0] tx_mux_q;
   logic [usrp_pkg::data_w-1:0] mode_q;
   logic [usrp_pkg::data_w-1:0] interp_q;
   logic [usrp_pkg::data_w-1:0] decim_q;
   logic [usrp_pkg::data_w-1:0] ctrl_q;

   // Read-only and unmapped addresses fall through
   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
      begin
         tx_mux_q <= '0;
         mode_q   <= '0;
         interp_q <= '0;
         decim_q  <= '0;
         ctrl_q   <= '0;
      end
      else if (i_wr_strobe)
      begin
         case (i_wr_addr)
            usrp_pkg::reg_tx_mux:      tx_mux_q <= i_wr_data;
            usrp_pkg::reg_mode:        mode_q   <= i_wr_data;
            usrp_pkg::reg_interp_rate: interp_q <= i_wr_data;
            usrp_pkg::reg_decim_rate:  decim_q  <= i_wr_data;
            usrp_pkg::reg_master_ctrl: ctrl_q   <= i_wr_data;
            default:                   ;
         endcase
      end
   end

   always_comb
   begin
      case (i_rd_addr)
         usrp_pkg::reg_tx_mux:      o_rdata = tx_mux_q;
         usrp_pkg::reg_mode:        o_rdata = mode_q;
         usrp_pkg::reg_interp_rate: o_rdata = interp_q;
         usrp_pkg::reg_decim_rate:  o_rdata = decim_q;
         usrp_pkg::reg_master_ctrl: o_rdata = ctrl_q;
         usrp_pkg::reg_caps:        o_rdata = usrp_pkg::caps_word;
         usrp_pkg::reg_id:          o_rdata = usrp_pkg::id_word;
         default:                   o_rdata = '0;
      endcase
   end

   // Fields out to the datapath
   assign o_tx_mux       = tx_mux_q;
   assign o_loopback     = mode_q[usrp_pkg::mode_loopback_bit];
   assign o_counter_mode = mode_q[usrp_pkg::mode_counter_bit];
   assign o_interp_rate  = interp_q[usrp_pkg::rate_w-1:0];
   assign o_decim_rate   = decim_q[usrp_pkg::rate_w-1:0];
   assign o_enable_tx    = ctrl_q[usrp_pkg::ctrl_enable_tx_bit];
   assign o_enable_rx    = ctrl_q[usrp_pkg::ctrl_enable_rx_bit];

endmodule

`default_nettype wire

//--- design/rate_strobe_gen.sv
/*
 * Rate strobes
 * Sample strobe toggle, interpolation and decimation down-counters
 */
`timescale 1ns/1ns
`default_nettype none

module rate_strobe_gen (
   input  wire                          clk64,
   input  wire                          rx_dsp_reset,
   input  wire                          i_enable_tx,
   input  wire                          i_enable_rx,
   input  wire  [usrp_pkg::rate_w-1:0]  i_interp_rate,
   input  wire  [usrp_pkg::rate_w-1:0]  i_decim_rate,
   output logic                         o_sample_strobe,
   output logic                         o_interp_strobe,
   output logic                         o_decim_strobe
);

   logic [usrp_pkg::rate_w-1:0] interp_cnt;
   logic [usrp_pkg::rate_w-1:0] decim_cnt;

   // Transmit side, counts sample strobe highs
   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset || !i_enable_tx)
      begin
         o_sample_strobe <= 1'b0;
         o_interp_strobe <= 1'b0;
         interp_cnt      <= rx_dsp_reset ? '0 : i_interp_rate;
      end
      else
      begin
         o_sample_strobe <= ~o_sample_strobe;
         o_interp_strobe <= o_sample_strobe && (interp_cnt == '0);
         if (o_sample_strobe)
            interp_cnt <= (interp_cnt == '0) ? i_interp_rate : interp_cnt - 1'b1;
      end
   end

   // Receive side, counts every clock
   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset || !i_enable_rx)
      begin
         o_decim_strobe <= 1'b0;
         decim_cnt      <= rx_dsp_reset ? '0 : i_decim_rate;
      end
      else
      begin
         o_decim_strobe <= (decim_cnt == '0);
         decim_cnt      <= (decim_cnt == '0) ? i_decim_rate : decim_cnt - 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- design/tx_dac_mux.sv
/*
 * Transmit DAC routing
 * Slot code decode and interleaving onto two registered DAC buses
 */
`timescale 1ns/1ns
`default_nettype none

module tx_dac_mux (
   input  wire                            clk64,
   input  wire                            rx_dsp_reset,
   input  wire   [usrp_pkg::data_w-1:0]   i_tx_mux,
   input  wire                            i_sample_strobe,
   input  wire   [usrp_pkg::sample_w-1:0] i_tx_i0,
   input  wire   [usrp_pkg::sample_w-1:0] i_tx_q0,
   input  wire   [usrp_pkg::sample_w-1:0] i_tx_i1,
   input  wire   [usrp_pkg::sample_w-1:0] i_tx_q1,
   output logic  [usrp_pkg::dac_w-1:0]    o_tx_a,
   output logic  [usrp_pkg::dac_w-1:0]    o_tx_b,
   output logic                           o_txsync
);

   logic [usrp_pkg::sample_w-1:0] slot_val [usrp_pkg::dac_slots];

   for (genvar n = 0; n < usrp_pkg::dac_slots; n++)
   begin : g_slot
      logic [usrp_pkg::slot_code_w-1:0] code;
      logic [usrp_pkg::sample_w-1:0]    pick;

      assign code = i_tx_mux[usrp_pkg::tx_slot0_lsb + n*usrp_pkg::slot_code_w
                             +: usrp_pkg::slot_code_w];

      // Channel bit picks the pair, Q bit picks within it
      always_comb
      begin
         if (code[usrp_pkg::mux_chan_bit])
            pick = code[usrp_pkg::mux_q_bit] ? i_tx_q1 : i_tx_i1;
         else
            pick = code[usrp_pkg::mux_q_bit] ? i_tx_q0 : i_tx_i0;
      end

      assign slot_val[n] = code[usrp_pkg::mux_en_bit] ? pick : '0;
   end

   // Odd slots go out while txsync is high, DAC takes the top bits
   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
      begin
         o_tx_a   <= '0;
         o_tx_b   <= '0;
         o_txsync <= 1'b0;
      end
      else
      begin
         o_txsync <= i_sample_strobe;
         o_tx_a   <= i_sample_strobe
                     ? slot_val[1][usrp_pkg::sample_w-1 -: usrp_pkg::dac_w]
                     : slot_val[0][usrp_pkg::sample_w-1 -: usrp_pkg::dac_w];
         o_tx_b   <= i_sample_strobe
                     ? slot_val[3][usrp_pkg::sample_w-1 -: usrp_pkg::dac_w]
                     : slot_val[2][usrp_pkg::sample_w-1 -: usrp_pkg::dac_w];
      end
   end

endmodule

`default_nettype wire

//--- design/rx_source_sel.sv
/*
 * Receive source selection
 * Loopback capture, debug ramp counter, channel output registers
 */
`timescale 1ns/1ns
`default_nettype none

module rx_source_sel (
   input  wire                            clk64,
   input  wire                            rx_dsp_reset,
   input  wire                            i_enable_rx,
   input  wire                            i_loopback,
   input  wire                            i_counter_mode,
   input  wire                            i_interp_strobe,
   input  wire                            i_decim_strobe,
   input  wire   [usrp_pkg::sample_w-1:0] i_tx_i0,
   input  wire   [usrp_pkg::sample_w-1:0] i_tx_q0,
   input  wire   [usrp_pkg::sample_w-1:0] i_adc_i0,
   input  wire   [usrp_pkg::sample_w-1:0] i_adc_q0,
   input  wire   [usrp_pkg::sample_w-1:0] i_adc_i1,
   input  wire   [usrp_pkg::sample_w-1:0] i_adc_q1,
   output logic  [usrp_pkg::sample_w-1:0] o_rx_ch0,
   output logic  [usrp_pkg::sample_w-1:0] o_rx_ch1,
   output logic  [usrp_pkg::sample_w-1:0] o_rx_ch2,
   output logic  [usrp_pkg::sample_w-1:0] o_rx_ch3,
   output logic                           o_rx_strobe
);

   logic [usrp_pkg::sample_w-1:0] loop_i;
   logic [usrp_pkg::sample_w-1:0] loop_q;
   logic [usrp_pkg::sample_w-1:0] ramp;

   // Transmit channel 0 as it is handed to the baseband
   always_ff @(posedge clk64)
   begin
      if (i_interp_strobe)
      begin
         loop_i <= i_tx_i0;
         loop_q <= i_tx_q0;
      end
   end

   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset || !i_enable_rx)
         ramp <= '0;
      else if (i_decim_strobe)
         ramp <= ramp + 16'd2;
   end

   // Counter wins over loopback; ch0 and ch1 see the ramp before its step
   always_ff @(posedge clk64)
   begin
      if (i_decim_strobe)
      begin
         if (i_counter_mode)
         begin
            o_rx_ch0 <= ramp;
            o_rx_ch1 <= ramp + 16'd1;
         end
         else if (i_loopback)
         begin
            o_rx_ch0 <= loop_i;
            o_rx_ch1 <= loop_q;
         end
         else
         begin
            o_rx_ch0 <= i_adc_i0;
            o_rx_ch1 <= i_adc_q0;
         end
         o_rx_ch2 <= i_adc_i1;
         o_rx_ch3 <= i_adc_q1;
      end
   end

   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
         o_rx_strobe <= 1'b0;
      else
         o_rx_strobe <= i_decim_strobe;
   end

endmodule

`default_nettype wire

//--- design/usrp_core_top.sv
/*
 * clk64 control and sample routing core
 * APB slave, settings bank, rate strobes, DAC routing, receive selection
 */
`timescale 1ns/1ns
`default_nettype none

module usrp_core_top (
   input  wire                            clk64,
   input  wire                            rx_dsp_reset,
   input  wire                            i_psel,
   input  wire                            i_penable,
   input  wire                            i_pwrite,
   input  wire   [usrp_pkg::addr_w-1:0]   i_paddr,
   input  wire   [usrp_pkg::data_w-1:0]   i_pwdata,
   output logic  [usrp_pkg::data_w-1:0]   o_prdata,
   output logic                           o_pready,
   input  wire   [usrp_pkg::sample_w-1:0] i_tx_i0,
   input  wire   [usrp_pkg::sample_w-1:0] i_tx_q0,
   input  wire   [usrp_pkg::sample_w-1:0] i_tx_i1,
   input  wire   [usrp_pkg::sample_w-1:0] i_tx_q1,
   input  wire   [usrp_pkg::sample_w-1:0] i_adc_i0,
   input  wire   [usrp_pkg::sample_w-1:0] i_adc_q0,
   input  wire   [usrp_pkg::sample_w-1:0] i_adc_i1,
   input  wire   [usrp_pkg::sample_w-1:0] i_adc_q1,
   output logic  [usrp_pkg::dac_w-1:0]    o_tx_a,
   output logic  [usrp_pkg::dac_w-1:0]    o_tx_b,
   output logic                           o_txsync,
   output logic  [usrp_pkg::sample_w-1:0] o_rx_ch0,
   output logic  [usrp_pkg::sample_w-1:0] o_rx_ch1,
   output logic  [usrp_pkg::sample_w-1:0] o_rx_ch2,
   output logic  [usrp_pkg::sample_w-1:0] o_rx_ch3,
   output logic                           o_rx_strobe,
   output logic                           o_interp_strobe
);

   // Register access path
   logic                        wr_strobe;
   logic [usrp_pkg::addr_w-1:0] wr_addr;
   logic [usrp_pkg::data_w-1:0] wr_data;
   logic [usrp_pkg::addr_w-1:0] rd_addr;
   logic [usrp_pkg::data_w-1:0] rdata;

   // Settings out to the datapath
   logic [usrp_pkg::data_w-1:0] tx_mux;
   logic                        loopback;
   logic                        counter_mode;
   logic [usrp_pkg::rate_w-1:0] interp_rate;
   logic [usrp_pkg::rate_w-1:0] decim_rate;
   logic                        enable_tx;
   logic                        enable_rx;

   logic                        sample_strobe;
   logic                        decim_strobe;

   apb_reg_fsm u_apb (
      .clk64        (clk64),
      .rx_dsp_reset (rx_dsp_reset),
      .i_psel       (i_psel),
      .i_penable    (i_penable),
      .i_pwrite     (i_pwrite),
      .i_paddr      (i_paddr),
      .i_pwdata     (i_pwdata),
      .i_rdata      (rdata),
      .o_prdata     (o_prdata),
      .o_pready     (o_pready),
      .o_wr_strobe  (wr_strobe),
      .o_wr_addr    (wr_addr),
      .o_wr_data    (wr_data),
      .o_rd_addr    (rd_addr)
   );

   settings_regs u_regs (
      .clk64          (clk64),
      .rx_dsp_reset   (rx_dsp_reset),
      .i_wr_strobe    (wr_strobe),
      .i_wr_addr      (wr_addr),
      .i_wr_data      (wr_data),
      .i_rd_addr      (rd_addr),
      .o_rdata        (rdata),
      .o_tx_mux       (tx_mux),
      .o_loopback     (loopback),
      .o_counter_mode (counter_mode),
      .o_interp_rate  (interp_rate),
      .o_decim_rate   (decim_rate),
      .o_enable_tx    (enable_tx),
      .o_enable_rx    (enable_rx)
   );

   rate_strobe_gen u_strobes (
      .clk64           (clk64),
      .rx_dsp_reset    (rx_dsp_reset),
      .i_enable_tx     (enable_tx),
      .i_enable_rx     (enable_rx),
      .i_interp_rate   (interp_rate),
      .i_decim_rate    (decim_rate),
      .o_sample_strobe (sample_strobe),
      .o_interp_strobe (o_interp_strobe),
      .o_decim_strobe  (decim_strobe)
   );

   tx_dac_mux u_dac (
      .clk64           (clk64),
      .rx_dsp_reset    (rx_dsp_reset),
      .i_tx_mux        (tx_mux),
      .i_sample_strobe (sample_strobe),
      .i_tx_i0         (i_tx_i0),
      .i_tx_q0         (i_tx_q0),
      .i_tx_i1         (i_tx_i1),
      .i_tx_q1         (i_tx_q1),
      .o_tx_a          (o_tx_a),
      .o_tx_b          (o_tx_b),
      .o_txsync        (o_txsync)
   );

   rx_source_sel u_rx (
      .clk64           (clk64),
      .rx_dsp_reset    (rx_dsp_reset),
      .i_enable_rx     (enable_rx),
      .i_loopback      (loopback),
      .i_counter_mode  (counter_mode),
      .i_interp_strobe (o_interp_strobe),
      .i_decim_strobe  (decim_strobe),
      .i_tx_i0         (i_tx_i0),
      .i_tx_q0         (i_tx_q0),
      .i_adc_i0        (i_adc_i0),
      .i_adc_q0        (i_adc_q0),
      .i_adc_i1        (i_adc_i1),
      .i_adc_q1        (i_adc_q1),
      .o_rx_ch0        (o_rx_ch0),
      .o_rx_ch1        (o_rx_ch1),
      .o_rx_ch2        (o_rx_ch2),
      .o_rx_ch3        (o_rx_ch3),
      .o_rx_strobe     (o_rx_strobe)
   );

endmodule

`default_nettype wire

//--- tb/tb_usrp_core.sv
/*
 * Testbench for the clk64 control and sample routing core
 * Clock, reset, APB access tasks, value check, directed tests, timeout
 */
`timescale 1ns/1ns
`default_nettype none

module tb_usrp_core;

   localparam int cycle_limit     = 4000;
   localparam int strobe_wait_max = 64;
   localparam logic [31:0] tx_en  = 32'd1 << usrp_pkg::ctrl_enable_tx_bit;
   localparam logic [31:0] rx_en  = 32'd1 << usrp_pkg::ctrl_enable_rx_bit;

   logic        clk64;
   logic        rx_dsp_reset;
   logic        i_psel;
   logic        i_penable;
   logic        i_pwrite;
   logic [6:0]  i_paddr;
   logic [31:0] i_pwdata;
   logic [15:0] i_tx_i0;
   logic [15:0] i_tx_q0;
   logic [15:0] i_tx_i1;
   logic [15:0] i_tx_q1;
   logic [15:0] i_adc_i0;
   logic [15:0] i_adc_q0;
   logic [15:0] i_adc_i1;
   logic [15:0] i_adc_q1;
   wire  [31:0] o_prdata;
   wire         o_pready;
   wire  [13:0] o_tx_a;
   wire  [13:0] o_tx_b;
   wire         o_txsync;
   wire  [15:0] o_rx_ch0;
   wire  [15:0] o_rx_ch1;
   wire  [15:0] o_rx_ch2;
   wire  [15:0] o_rx_ch3;
   wire         o_rx_strobe;
   wire         o_interp_strobe;

   int cycle_count = 0;

   usrp_core_top uut (
      .clk64(clk64), .rx_dsp_reset(rx_dsp_reset),
      .i_psel(i_psel), .i_penable(i_penable), .i_pwrite(i_pwrite),
      .i_paddr(i_paddr), .i_pwdata(i_pwdata), .o_prdata(o_prdata), .o_pready(o_pready),
      .i_tx_i0(i_tx_i0), .i_tx_q0(i_tx_q0), .i_tx_i1(i_tx_i1), .i_tx_q1(i_tx_q1),
      .i_adc_i0(i_adc_i0), .i_adc_q0(i_adc_q0), .i_adc_i1(i_adc_i1), .i_adc_q1(i_adc_q1),
      .o_tx_a(o_tx_a), .o_tx_b(o_tx_b), .o_txsync(o_txsync),
      .o_rx_ch0(o_rx_ch0), .o_rx_ch1(o_rx_ch1), .o_rx_ch2(o_rx_ch2), .o_rx_ch3(o_rx_ch3),
      .o_rx_strobe(o_rx_strobe), .o_interp_strobe(o_interp_strobe)
   );

   initial clk64 = 1'b0;
   always #2 clk64 = ~clk64;

   task automatic stop_run(input string reason);
      $display("%s", reason);
      $display("*** TEST FAILED ***");
      $fatal(1, "Simulation stopped on error");
   endtask

   always @(posedge clk64)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= cycle_limit)
         stop_run($sformatf("Timeout: run went past %0d clock cycles", cycle_limit));
   end

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected)
         stop_run($sformatf("MISMATCH at %0t ns: %s is %h, expected %h",
                            $time, name, actual, expected));
   endtask

   // Setup cycle followed by one access cycle with pready already high
   task automatic write_reg(input logic [6:0] addr, input logic [31:0] data);
      @(negedge clk64);
      i_psel    = 1'b1;
      i_penable = 1'b0;
      i_pwrite  = 1'b1;
      i_paddr   = addr;
      i_pwdata  = data;
      @(negedge clk64);
      i_penable = 1'b1;
      check_value("o_pready", {31'd0, o_pready}, 32'd1);
      @(negedge clk64);
      i_psel    = 1'b0;
      i_penable = 1'b0;
      i_pwrite  = 1'b0;
   endtask

   task automatic read_reg(input logic [6:0] addr, output logic [31:0] data);
      @(negedge clk64);
      i_psel    = 1'b1;
      i_penable = 1'b0;
      i_pwrite  = 1'b0;
      i_paddr   = addr;
      @(negedge clk64);
      i_penable = 1'b1;
      check_value("o_pready", {31'd0, o_pready}, 32'd1);
      data = o_prdata;
      @(negedge clk64);
      i_psel    = 1'b0;
      i_penable = 1'b0;
   endtask

   function automatic logic strobe_level(input int sel);
      return (sel == 0) ? o_interp_strobe : o_rx_strobe;
   endfunction

   // Cycles until the next high sample of the chosen strobe
   task automatic wait_strobe(input int sel, output int gap);
      @(negedge clk64);
      gap = 1;
      while (!strobe_level(sel) && gap < strobe_wait_max)
      begin
         @(negedge clk64);
         gap++;
      end
      if (!strobe_level(sel))
         stop_run($sformatf("%s did not pulse within %0d cycles",
                            (sel == 0) ? "o_interp_strobe" : "o_rx_strobe", strobe_wait_max));
   endtask

   // Expected DAC value as the upper 14 bits of the chosen sample
   function automatic logic [13:0] slot_expect(input logic [3:0] code);
      logic [15:0] sample;
      if (code[usrp_pkg::mux_chan_bit])
         sample = code[usrp_pkg::mux_q_bit] ? i_tx_q1 : i_tx_i1;
      else
         sample = code[usrp_pkg::mux_q_bit] ? i_tx_q0 : i_tx_i0;
      return code[usrp_pkg::mux_en_bit] ? sample[15:2] : 14'd0;
   endfunction

   task automatic reset_and_registers();
      logic [31:0] rd;
      logic [31:0] written [8];
      logic [31:0] expected;
      int a;
      check_value("o_pready", {31'd0, o_pready}, 32'd0);
      check_value("o_interp_strobe", {31'd0, o_interp_strobe}, 32'd0);
      check_value("o_rx_strobe", {31'd0, o_rx_strobe}, 32'd0);
      check_value("o_tx_a", {18'd0, o_tx_a}, 32'd0);
      check_value("o_tx_b", {18'd0, o_tx_b}, 32'd0);
      check_value("o_txsync", {31'd0, o_txsync}, 32'd0);
      for (a = 0; a < 8; a++)
      begin
         read_reg(a[6:0], rd);
         expected = (a == 6) ? usrp_pkg::caps_word : (a == 7) ? usrp_pkg::id_word : 32'd0;
         check_value($sformatf("o_prdata reg %0d after reset", a), rd, expected);
      end
      read_reg(7'h7F, rd);
      check_value("o_prdata unmapped reg", rd, 32'd0);
      // Write all five first so aliasing between words shows up
      for (a = 1; a < 6; a++)
      begin
         written[a] = $urandom;
         write_reg(a[6:0], written[a]);
      end
      for (a = 1; a < 6; a++)
      begin
         read_reg(a[6:0], rd);
         check_value($sformatf("o_prdata reg %0d readback", a), rd, written[a]);
      end
      write_reg(usrp_pkg::reg_caps, $urandom);
      write_reg(usrp_pkg::reg_id, $urandom);
      read_reg(usrp_pkg::reg_caps, rd);
      check_value("o_prdata caps after write", rd, usrp_pkg::caps_word);
      read_reg(usrp_pkg::reg_id, rd);
      check_value("o_prdata id after write", rd, usrp_pkg::id_word);
      for (a = 1; a < 6; a++)
         write_reg(a[6:0], 32'd0);
   endtask

   task automatic dac_routing();
      logic [15:0] rounds [3];
      logic [31:0] rnd;
      logic [13:0] exp_a;
      logic [13:0] exp_b;
      int          hi;
      int          lo;
      // Nibbles hold slots 3 to 0 and the last round has disabled codes 0 and 7
      rounds[0] = 16'hBA98;
      rounds[1] = 16'hFEDC;
      rounds[2] = 16'hE970;
      @(negedge clk64);
      i_tx_i0 = 16'($urandom);
      i_tx_q0 = 16'($urandom);
      i_tx_i1 = 16'($urandom);
      i_tx_q1 = 16'($urandom);
      write_reg(usrp_pkg::reg_master_ctrl, tx_en);
      for (int r = 0; r < 3; r++)
      begin
         rnd = $urandom;
         write_reg(usrp_pkg::reg_tx_mux, {12'h000, rounds[r], rnd[3:0]});
         @(negedge clk64);
         hi = 0;
         lo = 0;
         repeat (8)
         begin
            @(negedge clk64);
            exp_a = o_txsync ? slot_expect(rounds[r][7:4]) : slot_expect(rounds[r][3:0]);
            exp_b = o_txsync ? slot_expect(rounds[r][15:12]) : slot_expect(rounds[r][11:8]);
            check_value("o_tx_a", {18'd0, o_tx_a}, {18'd0, exp_a});
            check_value("o_tx_b", {18'd0, o_tx_b}, {18'd0, exp_b});
            if (o_txsync)
               hi++;
            else
               lo++;
         end
         check_value("o_txsync seen high", {31'd0, hi > 0}, 32'd1);
         check_value("o_txsync seen low", {31'd0, lo > 0}, 32'd1);
      end
      write_reg(usrp_pkg::reg_master_ctrl, 32'd0);
      write_reg(usrp_pkg::reg_tx_mux, 32'd0);
   endtask

   task automatic strobe_rates();
      int gap;
      write_reg(usrp_pkg::reg_interp_rate, 32'd3);
      write_reg(usrp_pkg::reg_decim_rate, 32'd4);
      write_reg(usrp_pkg::reg_master_ctrl, tx_en | rx_en);
      wait_strobe(0, gap);
      repeat (3)
      begin
         wait_strobe(0, gap);
         check_value("o_interp_strobe interval", gap, 32'd8);
      end
      wait_strobe(1, gap);
      repeat (3)
      begin
         wait_strobe(1, gap);
         check_value("o_rx_strobe interval", gap, 32'd5);
      end
      write_reg(usrp_pkg::reg_master_ctrl, 32'd0);
   endtask

   task automatic adc_passthrough();
      int gap;
      @(negedge clk64);
      i_adc_i0 = 16'($urandom);
      i_adc_q0 = 16'($urandom);
      i_adc_i1 = 16'($urandom);
      i_adc_q1 = 16'($urandom);
      write_reg(usrp_pkg::reg_mode, 32'd0);
      write_reg(usrp_pkg::reg_master_ctrl, rx_en);
      repeat (3)
      begin
         wait_strobe(1, gap);
         check_value("o_rx_ch0", {16'd0, o_rx_ch0}, {16'd0, i_adc_i0});
         check_value("o_rx_ch1", {16'd0, o_rx_ch1}, {16'd0, i_adc_q0});
         check_value("o_rx_ch2", {16'd0, o_rx_ch2}, {16'd0, i_adc_i1});
         check_value("o_rx_ch3", {16'd0, o_rx_ch3}, {16'd0, i_adc_q1});
      end
      write_reg(usrp_pkg::reg_master_ctrl, 32'd0);
   endtask

   task automatic loopback_path();
      int gap;
      @(negedge clk64);
      i_tx_i0 = 16'($urandom);
      i_tx_q0 = 16'($urandom);
      write_reg(usrp_pkg::reg_mode, 32'd1 << usrp_pkg::mode_loopback_bit);
      write_reg(usrp_pkg::reg_master_ctrl, tx_en | rx_en);
      wait_strobe(0, gap);
      // First receive load may still predate the capture
      wait_strobe(1, gap);
      repeat (2)
      begin
         wait_strobe(1, gap);
         check_value("o_rx_ch0 loopback", {16'd0, o_rx_ch0}, {16'd0, i_tx_i0});
         check_value("o_rx_ch1 loopback", {16'd0, o_rx_ch1}, {16'd0, i_tx_q0});
      end
      write_reg(usrp_pkg::reg_master_ctrl, 32'd0);
   endtask

   task automatic debug_ramp();
      int gap;
      // Both mode bits set so the counter must win over loopback
      write_reg(usrp_pkg::reg_mode, 32'd3);
      for (int pass = 0; pass < 2; pass++)
      begin
         write_reg(usrp_pkg::reg_master_ctrl, rx_en);
         for (int k = 0; k < 4; k++)
         begin
            wait_strobe(1, gap);
            check_value("o_rx_ch0 ramp", {16'd0, o_rx_ch0}, 32'(2 * k));
            check_value("o_rx_ch1 ramp", {16'd0, o_rx_ch1}, 32'(2 * k + 1));
         end
         write_reg(usrp_pkg::reg_master_ctrl, 32'd0);
      end
      write_reg(usrp_pkg::reg_mode, 32'd0);
   endtask

   initial
   begin
      void'($urandom(32'h539d_2090));
      rx_dsp_reset = 1'b1;
      i_psel       = 1'b0;
      i_penable    = 1'b0;
      i_pwrite     = 1'b0;
      i_paddr      = '0;
      i_pwdata     = '0;
      i_tx_i0      = '0;
      i_tx_q0      = '0;
      i_tx_i1      = '0;
      i_tx_q1      = '0;
      i_adc_i0     = '0;
      i_adc_q0     = '0;
      i_adc_i1     = '0;
      i_adc_q1     = '0;
      repeat (5) @(posedge clk64);
      @(negedge clk64);
      rx_dsp_reset = 1'b0;
      reset_and_registers();
      dac_routing();
      strobe_rates();
      adc_passthrough();
      loopback_path();
      debug_ramp();
      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

`default_nettype wire

//--- vlog.f
design/usrp_pkg.sv
design/apb_reg_fsm.sv
design/settings_regs.sv
design/rate_strobe_gen.sv
design/tx_dac_mux.sv
design/rx_source_sel.sv
design/usrp_core_top.sv
tb/tb_usrp_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator and run it, result taken from the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_usrp_core -o sim_tb

# The simulator exits non-zero on $fatal, the log search decides the result
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "\*\*\* TEST FAILED \*\*\*" sim.log; then
   exit 1
fi
if ! grep -q "\*\*\* TEST PASSED \*\*\*" sim.log; then
   echo "Simulation ended without a result line"
   exit 1
fi
exit 0
